/* verilog/enc_8b10b_settings.svh */
// widths follow the 8b/10b line code and are not meant to be changed

`ifndef ENC_8B10B_SETTINGS_SVH
`define ENC_8B10B_SETTINGS_SVH

// ------------------------------
// data path widths
// ------------------------------

`define ENC_DATA_W 8   // input byte HGFEDCBA
`define ENC_CODE_W 10  // code group abcdei fghj

// ------------------------------
// control characters
// ------------------------------

// low field that selects the comma sub-block when k_char is set
`define ENC_K28_X 5'd28

`endif

/* verilog/enc_8b10b_pkg.sv */
// running disparity is one bit everywhere in the encoder with 0 for RD- and 1 for RD+

`include "enc_8b10b_settings.svh"

package enc_8b10b_pkg;

    // ------------------------------
    // input byte
    // ------------------------------

    typedef struct packed {
        logic [2:0] y_val;  // HGF
        logic [4:0] x_val;  // EDCBA
    } enc_fields_t;

    // same byte seen raw or split into the two coder fields
    typedef union packed {
        logic [`ENC_DATA_W-1:0] raw;  // as on data_in
        enc_fields_t            f;
    } enc_byte_t;

    // ------------------------------
    // code sub-blocks
    // ------------------------------

    // first transmitted bit sits in the msb
    typedef logic [5:0] code6_t;  // abcdei
    typedef logic [3:0] code4_t;  // fghj

endpackage

/* verilog/enc_5b6b.sv */
// k_char only changes the result for x = 28 and other control codes are assumed valid

`timescale 1ns/1ps

`include "enc_8b10b_settings.svh"

module enc_5b6b (
    input  logic [4:0]            x_val,
    input  logic                  k_char,
    input  logic                  rd_cur,
    output enc_8b10b_pkg::code6_t code6,
    output logic                  rd_mid
);

    import enc_8b10b_pkg::*;

    code6_t code_neg;    // table entry in RD- form
    logic   is_k28;
    logic   unbalanced;  // two more ones than zeros
    logic   follow_rd;   // entry flips with rd_cur

    assign is_k28 = k_char && (x_val == `ENC_K28_X);

    // ------------------------------
    // 5b/6b table
    // ------------------------------

    always_comb begin
        if (is_k28) begin
            code_neg = 6'b001111;  // comma start
        end else begin
            case (x_val)
                5'd0:  code_neg = 6'b100111;
                5'd1:  code_neg = 6'b011101;
                5'd2:  code_neg = 6'b101101;
                5'd3:  code_neg = 6'b110001;
                5'd4:  code_neg = 6'b110101;
                5'd5:  code_neg = 6'b101001;
                5'd6:  code_neg = 6'b011001;
                5'd7:  code_neg = 6'b111000;  // balanced but still alternates
                5'd8:  code_neg = 6'b111001;
                5'd9:  code_neg = 6'b100101;
                5'd10: code_neg = 6'b010101;
                5'd11: code_neg = 6'b110100;
                5'd12: code_neg = 6'b001101;
                5'd13: code_neg = 6'b101100;
                5'd14: code_neg = 6'b011100;
                5'd15: code_neg = 6'b010111;
                5'd16: code_neg = 6'b011011;
                5'd17: code_neg = 6'b100011;
                5'd18: code_neg = 6'b010011;
                5'd19: code_neg = 6'b110010;
                5'd20: code_neg = 6'b001011;
                5'd21: code_neg = 6'b101010;
                5'd22: code_neg = 6'b011010;
                5'd23: code_neg = 6'b111010;
                5'd24: code_neg = 6'b110011;
                5'd25: code_neg = 6'b100110;
                5'd26: code_neg = 6'b010110;
                5'd27: code_neg = 6'b110110;
                5'd28: code_neg = 6'b001110;  // data only
                5'd29: code_neg = 6'b101110;
                5'd30: code_neg = 6'b011110;
                default: code_neg = 6'b101011;  // D.31
            endcase
        end
    end

    // ------------------------------
    // disparity selection
    // ------------------------------

    // every RD- entry is balanced or carries a surplus of ones
    assign unbalanced = ($countones(code_neg) != 3);

    // D.7 avoids a run of six by swapping its balanced form
    assign follow_rd = unbalanced || (x_val == 5'd7);

    assign code6 = (rd_cur && follow_rd) ? ~code_neg : code_neg;

    // unbalanced block always moves RD to the other side
    assign rd_mid = rd_cur ^ unbalanced;

endmodule

/* verilog/enc_3b4b.sv */
// assumes rd_mid and code6 come from the 5b/6b stage of the same character

`timescale 1ns/1ps

module enc_3b4b (
    input  logic [2:0]            y_val,
    input  logic                  k_char,
    input  logic                  rd_mid,
    input  enc_8b10b_pkg::code6_t code6,
    output enc_8b10b_pkg::code4_t code4,
    output logic                  rd_next
);

    import enc_8b10b_pkg::*;

    code4_t code_neg;    // RD- form
    logic   use_a7;
    logic   unbalanced;
    logic   swap;

    // ------------------------------
    // alternate .7 selection
    // ------------------------------

    // A7 keeps the run at the e/i to f boundary below five
    assign use_a7 = k_char
                 || (!rd_mid && code6[1:0] == 2'b11)
                 || ( rd_mid && code6[1:0] == 2'b00);

    // ------------------------------
    // 3b/4b table
    // ------------------------------

    always_comb begin
        case (y_val)
            3'd0: code_neg = 4'b1011;
            3'd1: code_neg = 4'b1001;
            3'd2: code_neg = 4'b0101;
            3'd3: code_neg = 4'b1100;  // balanced and alternating
            3'd4: code_neg = 4'b1101;
            3'd5: code_neg = 4'b1010;
            3'd6: code_neg = 4'b0110;
            default: begin
                if (use_a7) begin
                    code_neg = 4'b0111;
                end else begin
                    code_neg = 4'b1110;  // P7
                end
            end
        endcase
    end

    assign unbalanced = ($countones(code_neg) != 2);

    // control chars flip the balanced entries at RD- so the comma stays unique
    always_comb begin
        if (unbalanced || y_val == 3'd3) begin
            swap = rd_mid;
        end else if (k_char) begin
            swap = !rd_mid;  // .1 .2 .5 .6
        end else begin
            swap = 1'b0;
        end
    end

    assign code4   = swap ? ~code_neg : code_neg;
    assign rd_next = rd_mid ^ unbalanced;

endmodule

/* verilog/enc_disparity_reg.sv */
// stored RD resets to RD- and holds across idle cycles while the code group reads zero

`timescale 1ns/1ps

`include "enc_8b10b_settings.svh"

module enc_disparity_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   init_rd_n,
    input  logic                   init_rd_val,
    input  logic                   rd_next,
    input  enc_8b10b_pkg::code6_t  code6,
    input  enc_8b10b_pkg::code4_t  code4,
    output logic                   rd_cur,
    output logic                   rd,
    output logic [`ENC_CODE_W-1:0] data_out,
    output logic                   out_valid
);

    // external RD overrides the stored one while init_rd_n is low
    assign rd_cur = init_rd_n ? rd : init_rd_val;

    // ------------------------------
    // running disparity
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd <= 1'b0;  // RD-
        end else if (enable) begin
            rd <= rd_next;
        end
    end

    // ------------------------------
    // output code group
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out  <= '0;
            out_valid <= 1'b0;
        end else if (enable) begin
            data_out  <= {code6, code4};  // abcdei then fghj
            out_valid <= 1'b1;
        end else begin
            data_out  <= '0;
            out_valid <= 1'b0;
        end
    end

endmodule

/* verilog/enc_8b10b.sv */
// one byte per enabled cycle with one cycle latency and no back-pressure

`timescale 1ns/1ps

`include "enc_8b10b_settings.svh"

module enc_8b10b (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,       // byte valid this cycle
    input  logic                   k_char,       // control character
    input  logic [`ENC_DATA_W-1:0] data_in,
    input  logic                   init_rd_n,    // low to take init_rd_val
    input  logic                   init_rd_val,
    output logic [`ENC_CODE_W-1:0] data_out,
    output logic                   out_valid,
    output logic                   rd
);

    import enc_8b10b_pkg::*;

    enc_byte_t in_byte;
    code6_t    code6;
    code4_t    code4;
    logic      rd_cur;
    logic      rd_mid;
    logic      rd_next;

    assign in_byte = enc_byte_t'(data_in);

    // ------------------------------
    // table stages
    // ------------------------------

    enc_5b6b enc_5b6b_i (
        .x_val  (in_byte.f.x_val),
        .k_char (k_char),
        .rd_cur (rd_cur),
        .code6  (code6),
        .rd_mid (rd_mid)
    );

    enc_3b4b enc_3b4b_i (
        .y_val   (in_byte.f.y_val),
        .k_char  (k_char),
        .rd_mid  (rd_mid),
        .code6   (code6),
        .code4   (code4),
        .rd_next (rd_next)
    );

    // RD state and output register
    enc_disparity_reg enc_disparity_reg_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .init_rd_n   (init_rd_n),
        .init_rd_val (init_rd_val),
        .rd_next     (rd_next),
        .code6       (code6),
        .code4       (code4),
        .rd_cur      (rd_cur),
        .rd          (rd),
        .data_out    (data_out),
        .out_valid   (out_valid)
    );

endmodule

/* verification/tb_enc_8b10b_ref.svh */
// model built from the RD- tables only and valid for the twelve standard K codes alone

`ifndef TB_ENC_8B10B_REF_SVH
`define TB_ENC_8B10B_REF_SVH

// ------------------------------
// code tables in RD- form
// ------------------------------

localparam logic [0:31][5:0] ref_tab6_neg = {
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

localparam logic [0:7][3:0] ref_tab4_neg = {
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110  // .7 is P7
};

localparam logic [3:0] ref_a7_neg = 4'b0111;

// K28.0 to K28.7 then K23.7 K27.7 K29.7 K30.7
localparam logic [0:11][7:0] ref_k_codes = {
    8'h1c, 8'h3c, 8'h5c, 8'h7c, 8'h9c, 8'hbc, 8'hdc, 8'hfc, 8'hf7, 8'hfb, 8'hfd, 8'hfe
};

// ------------------------------
// pseudo random bits
// ------------------------------

logic [31:0] lfsr_state = 32'h8c93_6286;

// Fibonacci taps 32 22 2 1 stepped once per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

// ------------------------------
// character model
// ------------------------------

// result is {rd after, abcdei, fghj}
function automatic logic [10:0] ref_encode(input logic [7:0] b, input logic k,
                                           input logic rd_in);
    logic [5:0] c6;
    logic [3:0] c4;
    logic       rd_m;
    logic       rd_o;
    c6 = ref_tab6_neg[b[4:0]];
    if (k && b[4:0] == 5'd28) begin
        c6 = 6'b001111;  // comma start replaces D.28
    end
    // RD+ form is the complement and D.7 alternates although balanced
    if (rd_in && ($countones(c6) != 3 || b[4:0] == 5'd7)) begin
        c6 = ~c6;
    end
    rd_m = ($countones(c6) == 3) ? rd_in : !rd_in;
    c4 = ref_tab4_neg[b[7:5]];
    if (b[7:5] == 3'd7 && (k || (!rd_m && c6[1:0] == 2'b11) || (rd_m && c6[1:0] == 2'b00))) begin
        c4 = ref_a7_neg;
    end
    if ($countones(c4) != 2 || b[7:5] == 3'd3) begin
        if (rd_m) begin
            c4 = ~c4;
        end
    end else if (k && !rd_m) begin
        c4 = ~c4;  // control .1 .2 .5 .6
    end
    rd_o = ($countones(c4) == 2) ? rd_m : !rd_m;
    return {rd_o, c6, c4};
endfunction

`endif

/* verification/tb_enc_8b10b.sv */
// drives only the twelve valid K codes and keeps init_rd_n high outside the control test

`timescale 1ns/1ps

`include "enc_8b10b_settings.svh"

module tb_enc_8b10b;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   enable;
    logic                   k_char;
    logic [`ENC_DATA_W-1:0] data_in;
    logic                   init_rd_n;
    logic                   init_rd_val;
    logic [`ENC_CODE_W-1:0] data_out;
    logic                   out_valid;
    logic                   rd;

    int   mismatch_errors = 0;
    int   rule_errors = 0;
    int   reset_errors = 0;
    logic model_rd = 1'b0;  // expected stored RD
    int   run_len = 0;      // equal bits seen on the line so far
    logic run_bit = 1'b0;

    `include "tb_enc_8b10b_ref.svh"

    enc_8b10b enc_8b10b_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .k_char      (k_char),
        .data_in     (data_in),
        .init_rd_n   (init_rd_n),
        .init_rd_val (init_rd_val),
        .data_out    (data_out),
        .out_valid   (out_valid),
        .rd          (rd)
    );

    always #50 clk = ~clk;

    // outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!out_valid && data_out == '0 && !rd))
        else begin
            reset_errors++;
            $display("Mismatch in reset: out_valid %h data_out %h rd %h", out_valid, data_out, rd);
        end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d mismatch, %0d rule, %0d reset",
                 mismatch_errors, rule_errors, reset_errors);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic wait_for_valid(input int limit, output logic seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            #1;
            n++;
            seen = out_valid;
        end
    endtask

    // disparity bounds and run length of one code group on the line
    task automatic check_line(input logic [9:0] word, input logic rd_prior);
        logic [9:0] bits;
        int         ones;
        int         i;
        ones = $countones(word);
        assert (ones >= 4 && ones <= 6 && !(ones == 6 && rd_prior) && !(ones == 4 && !rd_prior))
            else begin
                rule_errors++;
                $display("code group %h has %0d ones after RD %0d", word, ones, rd_prior);
            end
        bits = word;
        for (i = 0; i < 10; i++) begin
            if (run_len > 0 && bits[9] == run_bit) begin
                run_len++;
            end else begin
                run_bit = bits[9];
                run_len = 1;
            end
            assert (run_len != 6) else begin
                rule_errors++;
                $display("run of six equal bits inside code group %h", word);
            end
            bits = bits << 1;  // a goes out first
        end
    endtask

    // one input cycle and the check of its result one edge later
    task automatic send_char(input logic en, input logic k, input logic [`ENC_DATA_W-1:0] b,
                             input logic init_n, input logic init_val, output logic [9:0] word);
        logic [10:0] expected;
        logic        rd_prior;
        logic        seen;
        enable      = en;
        k_char      = k;
        data_in     = b;
        init_rd_n   = init_n;
        init_rd_val = init_val;
        rd_prior    = init_n ? model_rd : init_val;
        expected    = en ? ref_encode(b, k, rd_prior) : {model_rd, 10'h000};
        wait_for_valid(1, seen);
        word = data_out;
        if (en && !seen) begin
            abort_run("out_valid did not follow an accepted byte within one cycle");
        end else begin
            assert (out_valid == en) else begin
                mismatch_errors++;
                $display("Mismatch out_valid: got %h expected %h", out_valid, en);
            end
            assert (data_out == expected[9:0]) else begin
                mismatch_errors++;
                $display("Mismatch data_out: got %h expected %h (byte %h k %h)",
                         data_out, expected[9:0], b, k);
            end
            assert (rd == expected[10]) else begin
                mismatch_errors++;
                $display("Mismatch rd: got %h expected %h", rd, expected[10]);
            end
            model_rd = expected[10];
            if (!en || !init_n) begin
                run_len = 0;  // line restarts
            end
            if (en) begin
                check_line(data_out, rd_prior);
            end
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        logic [31:0] r;
        logic [9:0]  word;
        logic [3:0]  k_idx;
        logic [7:0]  kb;
        int          i;
        int          j;
        rst_n       = 1'b1;
        enable      = 1'b0;
        k_char      = 1'b0;
        data_in     = '0;
        init_rd_n   = 1'b1;
        init_rd_val = 1'b0;
        #1;
        rst_n = 1'b0;
        for (i = 0; i < 2; i++) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        assert (!out_valid && data_out == '0 && !rd) else begin
            reset_errors++;
            $display("Mismatch after reset: out_valid %h data_out %h rd %h",
                     out_valid, data_out, rd);
        end

        // back to back data bytes
        for (i = 0; i < 64; i++) begin
            r = take_bits(8);
            send_char(1'b1, 1'b0, r[7:0], 1'b1, 1'b0, word);
        end

        // every control code from both starting RDs
        for (k_idx = 4'd0; k_idx < 4'd12; k_idx++) begin
            for (j = 0; j < 2; j++) begin
                kb = ref_k_codes[k_idx];
                send_char(1'b1, 1'b1, kb, 1'b0, j[0], word);
                if (kb[4:0] == `ENC_K28_X) begin
                    assert (word[9:4] == 6'b001111 || word[9:4] == 6'b110000) else begin
                        rule_errors++;
                        $display("K28 code group %h lacks the comma sub-block", word);
                    end
                    // comma run only in K28.1 .5 .7
                    if (kb[7:5] == 3'd1 || kb[7:5] == 3'd5 || kb[7:5] == 3'd7) begin
                        assert (word[7:3] == 5'b11111 || word[7:3] == 5'b00000) else begin
                            rule_errors++;
                            $display("comma code group %h has no run of five", word);
                        end
                    end
                end
                if (kb[7:5] == 3'd7) begin
                    assert (word[3:0] == 4'b0111 || word[3:0] == 4'b1000) else begin
                        rule_errors++;
                        $display("control code group %h does not end in A7", word);
                    end
                end
            end
        end

        // idle gaps of one to four cycles
        for (i = 0; i < 8; i++) begin
            r = take_bits(8);
            send_char(1'b1, 1'b0, r[7:0], 1'b1, 1'b0, word);
            r = take_bits(2);
            for (j = 0; j <= int'(r[1:0]); j++) begin
                send_char(1'b0, 1'b0, 8'h00, 1'b1, 1'b0, word);
            end
        end

        // long mixed stream
        for (i = 0; i < 1500; i++) begin
            r = take_bits(3);
            if (r[2:0] == 3'd0) begin
                send_char(1'b0, 1'b0, 8'h00, 1'b1, 1'b0, word);
            end else begin
                r = take_bits(4);
                if (r[3:0] == 4'd0) begin
                    r     = take_bits(4);
                    k_idx = (r[3:0] >= 4'd12) ? r[3:0] - 4'd12 : r[3:0];
                    send_char(1'b1, 1'b1, ref_k_codes[k_idx], 1'b1, 1'b0, word);
                end else begin
                    r = take_bits(8);
                    send_char(1'b1, 1'b0, r[7:0], 1'b1, 1'b0, word);
                end
            end
        end

        $display("errors: %0d mismatch, %0d rule, %0d reset",
                 mismatch_errors, rule_errors, reset_errors);
        if (mismatch_errors + rule_errors + reset_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        int n;
        for (n = 0; n < 4000; n++) begin
            @(posedge clk);
        end
        abort_run("watchdog expired before the stimulus finished");
    end

endmodule

/* vlog.f */
+incdir+verilog
+incdir+verification
verilog/enc_8b10b_pkg.sv
verilog/enc_5b6b.sv
verilog/enc_3b4b.sv
verilog/enc_disparity_reg.sv
verilog/enc_8b10b.sv
verification/tb_enc_8b10b.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -j 0 -f vlog.f \
    --top-module tb_enc_8b10b -o tb_enc_8b10b \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_enc_8b10b)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1
